//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_apb_ram
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+testbench
common/apb_mem_pkg.sv
ram/ram_singleport.sv
hw/apb_access_decode.sv
hw/apb_read_return.sv
hw/apb_ram_top.sv
testbench/tb_apb_ram.sv

//--- common/apb_mem_pkg.sv
`default_nettype none

package apb_mem_pkg;

    // ------------------------------------------------------------------
    // bus and memory geometry
    // ------------------------------------------------------------------
    localparam int DATA_WIDTH      = 32;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;
    localparam int PADDR_WIDTH     = 10;
    // word index is paddr[9:2]
    localparam int WORD_ADDR_WIDTH = PADDR_WIDTH - 2;
    // indices 192..255 fall in the unmapped hole
    localparam int MEM_WORDS       = 192;

    // ram output stage and resulting read latency
    localparam bit RAM_OUT_REG     = 1'b1;
    localparam int RAM_LATENCY     = 1 + int'(RAM_OUT_REG);

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [PADDR_WIDTH-1:0]     paddr_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [STRB_WIDTH-1:0]      strb_t;

    // power-up content of every mapped word
    localparam data_t MEM_FILL_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

//--- hw/apb_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module apb_access_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_mem_pkg::paddr_t     paddr,
    input  apb_mem_pkg::data_t      pwdata,
    input  apb_mem_pkg::strb_t      pstrb,
    input  logic                    done,
    output logic                    ram_en,
    output apb_mem_pkg::strb_t      ram_we,
    output apb_mem_pkg::word_addr_t ram_addr,
    output apb_mem_pkg::data_t      ram_din,
    output logic                    acc_start,
    output logic                    acc_err
);

    import apb_mem_pkg::*;

    // set from the first access cycle until the return side ends it
    logic       busy;
    word_addr_t word_idx;
    logic       in_range;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------
    // byte offset bits 1:0 are covered by pstrb
    assign word_idx = paddr[PADDR_WIDTH-1 -: WORD_ADDR_WIDTH];
    assign in_range = int'(word_idx) < MEM_WORDS;

    // first access-phase cycle only, a held phase is ignored
    assign acc_start = psel && penable && !busy;
    assign acc_err   = !in_range;

    // ------------------------------------------------------------------
    // ram request
    // ------------------------------------------------------------------
    assign ram_en   = acc_start && in_range;
    assign ram_we   = (ram_en && pwrite) ? pstrb : '0;
    assign ram_addr = word_idx;
    assign ram_din  = pwdata;

    // ------------------------------------------------------------------
    // in-flight tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (acc_start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // ram is only touched in the access cycle right after a setup cycle
    a_en_in_access: assert property (
        @(posedge clk) disable iff (rst)
        ram_en |-> (psel && penable && $past(psel && !penable))
    ) else $error("apb_access_decode: ram_en outside first access cycle");

    // return side only ends a transfer that is in flight
    a_single_start: assert property (
        @(posedge clk) disable iff (rst)
        done |-> busy
    ) else $error("apb_access_decode: done without a transfer in flight");

endmodule

`default_nettype wire

//--- hw/apb_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module apb_ram_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_mem_pkg::paddr_t paddr,
    input  apb_mem_pkg::data_t  pwdata,
    input  apb_mem_pkg::strb_t  pstrb,
    output logic                pready,
    output logic                pslverr,
    output apb_mem_pkg::data_t  prdata
);

    import apb_mem_pkg::*;

    // ------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------
    logic       ram_en;
    strb_t      ram_we;
    word_addr_t ram_addr;
    data_t      ram_din;
    data_t      ram_dout;
    logic       acc_start;
    logic       acc_err;

    // APB access phase to single ram access
    apb_access_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .done      (pready),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_din   (ram_din),
        .acc_start (acc_start),
        .acc_err   (acc_err)
    );

    // output stage must agree with RAM_LATENCY in the return block
    ram_singleport #(
        .OUT_REG (RAM_OUT_REG)
    ) u_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

    apb_read_return u_return (
        .clk       (clk),
        .rst       (rst),
        .acc_start (acc_start),
        .acc_err   (acc_err),
        .pwrite    (pwrite),
        .ram_dout  (ram_dout),
        .pready    (pready),
        .pslverr   (pslverr),
        .prdata    (prdata)
    );

endmodule

`default_nettype wire

//--- hw/apb_read_return.sv
`timescale 1ns/1ps
`default_nettype none

module apb_read_return (
    input  logic               clk,
    input  logic               rst,
    input  logic               acc_start,
    input  logic               acc_err,
    input  logic               pwrite,
    input  apb_mem_pkg::data_t ram_dout,
    output logic               pready,
    output logic               pslverr,
    output apb_mem_pkg::data_t prdata
);

    import apb_mem_pkg::*;

    // pending flags, stage k is valid k+1 cycles after acc_start
    logic [RAM_LATENCY-1:0] rd_pipe;
    logic [RAM_LATENCY-1:0] wr_pipe;
    // unmapped access, answered after one cycle
    logic                   err_q;

    // ------------------------------------------------------------------
    // latency tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
            wr_pipe <= '0;
            err_q   <= 1'b0;
        end else begin
            rd_pipe[0] <= acc_start && !acc_err && !pwrite;
            wr_pipe[0] <= acc_start && !acc_err && pwrite;
            for (int i = 1; i < RAM_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
                wr_pipe[i] <= wr_pipe[i-1];
            end
            err_q <= acc_start && acc_err;
        end
    end

    // ------------------------------------------------------------------
    // end stage
    // ------------------------------------------------------------------
    // last stage lines up with valid ram_dout
    assign pready  = rd_pipe[RAM_LATENCY-1] || wr_pipe[RAM_LATENCY-1] || err_q;
    assign pslverr = err_q;
    // zero for writes, errors and idle cycles
    assign prdata  = rd_pipe[RAM_LATENCY-1] ? ram_dout : '0;

    // single-cycle completion, even for back-to-back transfers
    a_pready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        pready |=> !pready
    ) else $error("apb_read_return: pready high for two cycles");

endmodule

`default_nettype wire

//--- ram/ram_singleport.sv
`timescale 1ns/1ps
`default_nettype none

module ram_singleport #(
    parameter bit OUT_REG = 1'b1
) (
    input  logic                    clk,
    input  logic                    en,
    input  apb_mem_pkg::strb_t      we,
    input  apb_mem_pkg::word_addr_t addr,
    input  apb_mem_pkg::data_t      din,
    output apb_mem_pkg::data_t      dout
);

    import apb_mem_pkg::*;

    // word as seen after the array read
    data_t rd_word;

    // ------------------------------------------------------------------
    // byte lanes, one array each, read-first
    // ------------------------------------------------------------------
    for (genvar i = 0; i < STRB_WIDTH; i++) begin : g_lane
        logic [7:0] lane_mem [MEM_WORDS];
        logic [7:0] rd_byte;

        always_ff @(posedge clk) begin
            if (en) begin
                if (we[i]) begin
                    lane_mem[addr] <= din[i*8 +: 8];
                end
                // old content goes out even on a write
                rd_byte <= lane_mem[addr];
            end
        end

        assign rd_word[i*8 +: 8] = rd_byte;

        // every word starts from the package fill value
        initial begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                lane_mem[w] = MEM_FILL_WORD[i*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // optional output stage
    // ------------------------------------------------------------------
    if (OUT_REG) begin : g_out_reg
        data_t dout_q;

        // loads every cycle, adds one cycle of latency
        always_ff @(posedge clk) begin
            dout_q <= rd_word;
        end

        assign dout = dout_q;
    end else begin : g_out_direct
        assign dout = rd_word;
    end

    // an enabled access must carry a defined word index
    a_addr_known: assert property (
        @(posedge clk) en |-> !$isunknown(addr)
    ) else $error("ram_singleport: unknown addr while en is high");

endmodule

`default_nettype wire

//--- testbench/tb_apb_ram_tasks.svh
`ifndef TB_APB_RAM_TASKS_SVH
`define TB_APB_RAM_TASKS_SVH

// ----------------------------------------------------------------------
// random source and reference model
// ----------------------------------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic data_t expected_read(input word_addr_t idx);
    return model_mem[idx];
endfunction

// only the lanes named in strb take the new bytes
function automatic data_t merge_write(input data_t old_word, input data_t new_word,
                                      input strb_t strb);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < STRB_WIDTH; i++) begin
        if (strb[i]) begin
            merged[i*8 +: 8] = new_word[i*8 +: 8];
        end
    end
    return merged;
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
        $display("ERR %s: expected %h, got %h", name, exp, act);
        fail_run();
    end
endtask

task automatic check_resp(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s: expected %h, got %h", name, exp, act);
        fail_run();
    end
endtask

task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
        $display("ERR pready latency: expected %0h cycles, got %0h", exp, act);
        fail_run();
    end
endtask

// ----------------------------------------------------------------------
// one APB transfer, setup then access until pready
// ----------------------------------------------------------------------
task automatic apb_transfer(input logic wr, input word_addr_t idx, input data_t wdata,
                            input strb_t strb);
    data_t exp_data;
    logic  exp_err;
    int    exp_lat;
    if (int'(idx) >= MEM_WORDS) begin
        // hole in the map, no ram access at all
        exp_err  = 1'b1;
        exp_data = '0;
        exp_lat  = 1;
    end else if (wr) begin
        model_mem[idx] = merge_write(model_mem[idx], wdata, strb);
        exp_err  = 1'b0;
        exp_data = '0;
        exp_lat  = RAM_LATENCY;
    end else begin
        exp_err  = 1'b0;
        exp_data = expected_read(idx);
        exp_lat  = RAM_LATENCY;
    end
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_lat_q.push_back(exp_lat);
    n_issued++;

    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= {idx, 2'b00};
    pwdata  <= wdata;
    pstrb   <= wr ? strb : '0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1) begin
        @(negedge clk);
    end
    // transfer completes on this edge
    @(posedge clk);
endtask

`endif

//--- testbench/tb_apb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_ram;

    import apb_mem_pkg::*;

    localparam int N_DIRECTED     = 28;
    localparam int N_RANDOM       = 300;
    localparam int TIMEOUT_CYCLES = 20 * (N_DIRECTED + N_RANDOM) + 200;
    localparam int UNMAPPED_WORDS = (1 << WORD_ADDR_WIDTH) - MEM_WORDS;

    logic   clk;
    logic   rst;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    data_t  pwdata;
    strb_t  pstrb;
    logic   pready;
    logic   pslverr;
    data_t  prdata;

    // reference model and responses still owed by the DUT
    data_t       model_mem [MEM_WORDS];
    data_t       exp_data_q [$];
    logic        exp_err_q [$];
    int          exp_lat_q [$];
    int          n_issued    = 0;
    int          n_done      = 0;
    int          cycle_count = 0;
    logic        in_access   = 1'b0;
    int          acc_cycles  = 0;
    logic [31:0] rng         = 32'h56f0;

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    `include "tb_apb_ram_tasks.svh"

    apb_ram_top uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        fail_run();
    end

    // ------------------------------------------------------------------
    // response checker, samples mid-cycle
    // ------------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk);
            if (rst === 1'b0) begin
                if (psel && penable && !in_access) begin
                    in_access  = 1'b1;
                    acc_cycles = 0;
                end else if (in_access) begin
                    acc_cycles++;
                end
                if (pready === 1'b1) begin
                    if (!in_access || exp_lat_q.size() == 0) begin
                        $display("pready was raised with no transfer in its access phase");
                        fail_run();
                    end else begin
                        check_latency(exp_lat_q.pop_front(), acc_cycles);
                        check_resp("pslverr", exp_err_q.pop_front(), pslverr);
                        check_data("prdata", exp_data_q.pop_front(), prdata);
                        in_access = 1'b0;
                        n_done++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] r_ctl;
        logic [31:0] r_data;
        int          pick;
        word_addr_t  idx;
        strb_t       part_strb [4];
        for (int w = 0; w < MEM_WORDS; w++) begin
            model_mem[w] = MEM_FILL_WORD;
        end
        part_strb[0] = 4'b0001;
        part_strb[1] = 4'b0110;
        part_strb[2] = 4'b1000;
        part_strb[3] = 4'b0000;
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        pstrb   <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // idle outputs straight after reset
        check_resp("pready", 1'b0, pready);
        check_resp("pslverr", 1'b0, pslverr);
        check_data("prdata", '0, prdata);
        @(posedge clk);

        // unwritten words still hold the fill value
        apb_transfer(1'b0, 8'd0, '0, '0);
        apb_transfer(1'b0, 8'd5, '0, '0);
        apb_transfer(1'b0, 8'd100, '0, '0);
        apb_transfer(1'b0, 8'd191, '0, '0);

        // full word write then read back
        apb_transfer(1'b1, 8'd0, 32'hdead_beef, 4'hf);
        apb_transfer(1'b0, 8'd0, '0, '0);
        apb_transfer(1'b1, 8'd63, 32'h1234_5678, 4'hf);
        apb_transfer(1'b0, 8'd63, '0, '0);
        apb_transfer(1'b1, 8'd191, 32'ha5c3_0ff1, 4'hf);
        apb_transfer(1'b0, 8'd191, '0, '0);

        // byte lane merges on one word
        apb_transfer(1'b1, 8'd10, 32'h0011_2233, 4'hf);
        for (int k = 0; k < 4; k++) begin
            apb_transfer(1'b1, 8'd10, 32'hffee_ddcc, part_strb[k]);
            apb_transfer(1'b0, 8'd10, '0, '0);
        end

        // unmapped hole, then mapped words must be untouched
        apb_transfer(1'b1, 8'd192, 32'hbad0_0001, 4'hf);
        apb_transfer(1'b1, 8'd200, 32'hbad0_0002, 4'hf);
        apb_transfer(1'b1, 8'd255, 32'hbad0_0003, 4'hf);
        apb_transfer(1'b0, 8'd192, '0, '0);
        apb_transfer(1'b0, 8'd230, '0, '0);
        apb_transfer(1'b0, 8'd0, '0, '0);
        apb_transfer(1'b0, 8'd8, '0, '0);
        apb_transfer(1'b0, 8'd63, '0, '0);
        apb_transfer(1'b0, 8'd191, '0, '0);

        // random mix, about one in eight hits the hole
        repeat (N_RANDOM) begin
            rng    = xorshift32(rng);
            r_ctl  = rng;
            rng    = xorshift32(rng);
            r_data = rng;
            if (r_ctl[3:1] == 3'd0) begin
                pick = MEM_WORDS + (int'(r_ctl[23:8]) % UNMAPPED_WORDS);
            end else begin
                pick = int'(r_ctl[23:8]) % MEM_WORDS;
            end
            idx = word_addr_t'(pick);
            apb_transfer(r_ctl[0], idx, r_data, r_ctl[7:4]);
        end

        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk);
        if (n_done == n_issued && n_issued == N_DIRECTED + N_RANDOM) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("only %0d of %0d transfers were checked", n_done, n_issued);
            fail_run();
        end
    end

endmodule

`default_nettype wire
